//--- logic/soc_pkg.sv
/*
 * SoC shared definitions
 * Wishbone request and response structs, address views, region codes
 * and register offsets for the boot memory, timer and interrupt controller
 */
package soc_pkg;

    // Bus widths
    localparam int WB_ADR_W = 32;
    localparam int WB_DAT_W = 32;
    localparam int WB_SEL_W = 4;

    localparam int REGION_W = 8;
    localparam int OFFSET_W = WB_ADR_W - REGION_W;

    // Bit 0 timer, bit 1 external pin
    localparam int INT_SRC_W = 2;

    // ----------------------------------------
    // Address map
    // ----------------------------------------
    localparam logic [REGION_W-1:0] REGION_BOOT  = 8'h00;
    localparam logic [REGION_W-1:0] REGION_TIMER = 8'h13;
    localparam logic [REGION_W-1:0] REGION_IC    = 8'h14;

    localparam logic [OFFSET_W-1:0] TIMER_LOAD  = 24'h00;
    localparam logic [OFFSET_W-1:0] TIMER_VALUE = 24'h04;
    localparam logic [OFFSET_W-1:0] TIMER_CTRL  = 24'h08;
    localparam logic [OFFSET_W-1:0] TIMER_CLEAR = 24'h0C;

    localparam logic [OFFSET_W-1:0] IC_STATUS      = 24'h00;
    localparam logic [OFFSET_W-1:0] IC_RAW         = 24'h04;
    localparam logic [OFFSET_W-1:0] IC_IRQ_EN_SET  = 24'h08;
    localparam logic [OFFSET_W-1:0] IC_IRQ_EN_CLR  = 24'h0C;
    localparam logic [OFFSET_W-1:0] IC_FIRQ_EN_SET = 24'h10;
    localparam logic [OFFSET_W-1:0] IC_FIRQ_EN_CLR = 24'h14;

    // ----------------------------------------
    // Bus types
    // ----------------------------------------
    typedef struct packed {
        logic [REGION_W-1:0] region;
        logic [OFFSET_W-1:0] offset;
    } wb_adr_fields_t;

    // Decoder looks at the region, slaves at the offset
    typedef union packed {
        logic [WB_ADR_W-1:0] word;
        wb_adr_fields_t      fields;
    } wb_adr_u;

    typedef struct packed {
        wb_adr_u             adr;
        logic [WB_SEL_W-1:0] sel;
        logic                we;
        logic [WB_DAT_W-1:0] dat;
        logic                cyc;
        logic                stb;
    } wb_req_t;

    typedef struct packed {
        logic [WB_DAT_W-1:0] dat;
        logic                ack;
        logic                err;
    } wb_rsp_t;

endpackage

//--- logic/wb_decoder.sv
/*
 * Wishbone address decoder
 * Routes the master strobe to one of three slaves by address region and
 * returns the selected response, or a registered err for unmapped space
 */
`timescale 1ns/1ps

module wb_decoder (
    input  logic             i_clk,
    input  logic             i_rst_n,

    // Master side
    input  soc_pkg::wb_req_t i_wb_req,
    output soc_pkg::wb_rsp_t o_wb_rsp,

    // Slave requests
    output soc_pkg::wb_req_t o_boot_req,
    output soc_pkg::wb_req_t o_timer_req,
    output soc_pkg::wb_req_t o_ic_req,

    // Slave responses
    input  soc_pkg::wb_rsp_t i_boot_rsp,
    input  soc_pkg::wb_rsp_t i_timer_rsp,
    input  soc_pkg::wb_rsp_t i_ic_rsp
);

    logic [soc_pkg::REGION_W-1:0] region;
    logic                         hit_boot;
    logic                         hit_timer;
    logic                         hit_ic;
    logic                         unmapped;
    logic                         err_r;

    assign region    = i_wb_req.adr.fields.region;
    assign hit_boot  = (region == soc_pkg::REGION_BOOT);
    assign hit_timer = (region == soc_pkg::REGION_TIMER);
    assign hit_ic    = (region == soc_pkg::REGION_IC);
    assign unmapped  = ~(hit_boot | hit_timer | hit_ic);

    // ----------------------------------------
    // Strobe routing
    // ----------------------------------------
    always_comb begin
        o_boot_req      = i_wb_req;
        o_timer_req     = i_wb_req;
        o_ic_req        = i_wb_req;
        o_boot_req.stb  = i_wb_req.stb & hit_boot;
        o_timer_req.stb = i_wb_req.stb & hit_timer;
        o_ic_req.stb    = i_wb_req.stb & hit_ic;
    end

    // One cycle err for accesses outside the map
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            err_r <= 1'b0;
        end else begin
            err_r <= i_wb_req.cyc & i_wb_req.stb & unmapped & ~err_r;
        end
    end

    // ----------------------------------------
    // Response multiplexer
    // ----------------------------------------
    // Master holds the address until after ack, so the live region selects
    always_comb begin
        case (region)
            soc_pkg::REGION_BOOT: begin
                o_wb_rsp = i_boot_rsp;
            end
            soc_pkg::REGION_TIMER: begin
                o_wb_rsp = i_timer_rsp;
            end
            soc_pkg::REGION_IC: begin
                o_wb_rsp = i_ic_rsp;
            end
            default: begin
                o_wb_rsp.dat = '0;
                o_wb_rsp.ack = 1'b0;
                o_wb_rsp.err = err_r;
            end
        endcase
    end

endmodule

//--- logic/boot_mem.sv
/*
 * Boot memory
 * Word addressed embedded SRAM with byte select writes and a registered ack
 */
`timescale 1ns/1ps

module boot_mem #(
    parameter int BOOT_MEM_WORDS = 256
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  soc_pkg::wb_req_t i_wb_req,
    output soc_pkg::wb_rsp_t o_wb_rsp
);

    localparam int IDX_W = $clog2(BOOT_MEM_WORDS);

    logic [soc_pkg::WB_DAT_W-1:0] mem [BOOT_MEM_WORDS];
    logic [IDX_W-1:0]             idx;
    logic                         start;
    logic                         ack_r;
    logic [soc_pkg::WB_DAT_W-1:0] rdata_r;

    // Byte offset bits are dropped, only word index is kept
    assign idx   = i_wb_req.adr.fields.offset[IDX_W+1:2];
    assign start = i_wb_req.cyc & i_wb_req.stb & ~ack_r;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ack_r <= 1'b0;
        end else begin
            ack_r <= start;
        end
    end

    // Write lands on the same edge that raises ack
    always_ff @(posedge i_clk) begin
        if (start && i_wb_req.we) begin
            for (int b = 0; b < soc_pkg::WB_SEL_W; b++) begin
                if (i_wb_req.sel[b]) begin
                    mem[idx][b*8 +: 8] <= i_wb_req.dat[b*8 +: 8];
                end
            end
        end
    end

    // Read data captured alongside ack
    always_ff @(posedge i_clk) begin
        if (start && !i_wb_req.we) begin
            rdata_r <= mem[idx];
        end
    end

    assign o_wb_rsp.dat = rdata_r;
    assign o_wb_rsp.ack = ack_r;
    assign o_wb_rsp.err = 1'b0;

endmodule

//--- logic/timer_module.sv
/*
 * Reloading down counter timer
 * Counts down once per cycle while enabled, reloads on zero and latches
 * an interrupt flag that software drops through the clear register
 */
`timescale 1ns/1ps

module timer_module (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  soc_pkg::wb_req_t i_wb_req,
    output soc_pkg::wb_rsp_t o_wb_rsp,
    output logic             o_timer_int
);

    logic [soc_pkg::OFFSET_W-1:0] offset;
    logic                         start;
    logic                         wr_en;
    logic                         rd_en;
    logic                         load_wr;
    logic                         wrap;
    logic                         ack_r;

    logic [soc_pkg::WB_DAT_W-1:0] load_r;
    logic [soc_pkg::WB_DAT_W-1:0] value_r;
    logic [soc_pkg::WB_DAT_W-1:0] ctrl_r;
    logic                         flag_r;
    logic [soc_pkg::WB_DAT_W-1:0] rdata_r;

    assign offset  = i_wb_req.adr.fields.offset;
    assign start   = i_wb_req.cyc & i_wb_req.stb & ~ack_r;
    assign wr_en   = start & i_wb_req.we;
    assign rd_en   = start & ~i_wb_req.we;
    assign load_wr = wr_en & (offset == soc_pkg::TIMER_LOAD);

    // Ctrl bit 0 enables counting
    assign wrap = ctrl_r[0] & (value_r == '0) & ~load_wr;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ack_r <= 1'b0;
        end else begin
            ack_r <= start;
        end
    end

    // ----------------------------------------
    // Registers and counter
    // ----------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            load_r  <= '0;
            value_r <= '0;
            ctrl_r  <= '0;
        end else begin
            if (wr_en && offset == soc_pkg::TIMER_CTRL) begin
                ctrl_r <= i_wb_req.dat;
            end
            // New load value restarts the count straight away
            if (load_wr) begin
                load_r  <= i_wb_req.dat;
                value_r <= i_wb_req.dat;
            end else if (wrap) begin
                value_r <= load_r;
            end else if (ctrl_r[0]) begin
                value_r <= value_r - 1'b1;
            end
        end
    end

    // Wrap wins over a clear in the same cycle so no event is lost
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            flag_r <= 1'b0;
        end else if (wrap) begin
            flag_r <= 1'b1;
        end else if (wr_en && offset == soc_pkg::TIMER_CLEAR) begin
            flag_r <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (rd_en) begin
            case (offset)
                soc_pkg::TIMER_LOAD:  rdata_r <= load_r;
                soc_pkg::TIMER_VALUE: rdata_r <= value_r;
                soc_pkg::TIMER_CTRL:  rdata_r <= ctrl_r;
                default:              rdata_r <= '0;
            endcase
        end
    end

    assign o_wb_rsp.dat = rdata_r;
    assign o_wb_rsp.ack = ack_r;
    assign o_wb_rsp.err = 1'b0;
    assign o_timer_int  = flag_r;

endmodule

//--- logic/interrupt_controller.sv
/*
 * Interrupt controller
 * Registers the timer and external sources and drives irq and firq
 * through separate enable masks with set and clear access
 */
`timescale 1ns/1ps

module interrupt_controller (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  soc_pkg::wb_req_t i_wb_req,
    output soc_pkg::wb_rsp_t o_wb_rsp,
    input  logic             i_timer_int,
    input  logic             i_ext_irq,
    output logic             o_irq,
    output logic             o_firq
);

    logic [soc_pkg::OFFSET_W-1:0]  offset;
    logic                          start;
    logic                          wr_en;
    logic                          rd_en;
    logic                          ack_r;
    logic [soc_pkg::INT_SRC_W-1:0] wr_bits;

    logic [soc_pkg::INT_SRC_W-1:0] raw_r;
    logic [soc_pkg::INT_SRC_W-1:0] irq_en_r;
    logic [soc_pkg::INT_SRC_W-1:0] firq_en_r;
    logic [soc_pkg::WB_DAT_W-1:0]  rd_word;
    logic [soc_pkg::WB_DAT_W-1:0]  rdata_r;

    assign offset  = i_wb_req.adr.fields.offset;
    assign start   = i_wb_req.cyc & i_wb_req.stb & ~ack_r;
    assign wr_en   = start & i_wb_req.we;
    assign rd_en   = start & ~i_wb_req.we;
    assign wr_bits = i_wb_req.dat[soc_pkg::INT_SRC_W-1:0];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ack_r <= 1'b0;
        end else begin
            ack_r <= start;
        end
    end

    // ----------------------------------------
    // Source capture and enable masks
    // ----------------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            raw_r     <= '0;
            irq_en_r  <= '0;
            firq_en_r <= '0;
        end else begin
            raw_r <= {i_ext_irq, i_timer_int};
            if (wr_en) begin
                case (offset)
                    soc_pkg::IC_IRQ_EN_SET:  irq_en_r  <= irq_en_r | wr_bits;
                    soc_pkg::IC_IRQ_EN_CLR:  irq_en_r  <= irq_en_r & ~wr_bits;
                    soc_pkg::IC_FIRQ_EN_SET: firq_en_r <= firq_en_r | wr_bits;
                    soc_pkg::IC_FIRQ_EN_CLR: firq_en_r <= firq_en_r & ~wr_bits;
                    default: ;
                endcase
            end
        end
    end

    // Set offsets read back the live mask
    always_comb begin
        rd_word = '0;
        case (offset)
            soc_pkg::IC_STATUS:      rd_word[soc_pkg::INT_SRC_W-1:0] = raw_r & irq_en_r;
            soc_pkg::IC_RAW:         rd_word[soc_pkg::INT_SRC_W-1:0] = raw_r;
            soc_pkg::IC_IRQ_EN_SET:  rd_word[soc_pkg::INT_SRC_W-1:0] = irq_en_r;
            soc_pkg::IC_FIRQ_EN_SET: rd_word[soc_pkg::INT_SRC_W-1:0] = firq_en_r;
            default:                 rd_word = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (rd_en) begin
            rdata_r <= rd_word;
        end
    end

    assign o_wb_rsp.dat = rdata_r;
    assign o_wb_rsp.ack = ack_r;
    assign o_wb_rsp.err = 1'b0;

    assign o_irq  = |(raw_r & irq_en_r);
    assign o_firq = |(raw_r & firq_en_r);

endmodule

//--- logic/soc_top.sv
/*
 * SoC top level
 * One Wishbone master port decoded onto boot memory, timer and
 * interrupt controller
 */
`timescale 1ns/1ps

module soc_top #(
    parameter int BOOT_MEM_WORDS = 256
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  soc_pkg::wb_req_t i_wb_req,
    output soc_pkg::wb_rsp_t o_wb_rsp,
    input  logic             i_ext_irq,
    output logic             o_irq,
    output logic             o_firq
);

    soc_pkg::wb_req_t boot_req;
    soc_pkg::wb_req_t timer_req;
    soc_pkg::wb_req_t ic_req;
    soc_pkg::wb_rsp_t boot_rsp;
    soc_pkg::wb_rsp_t timer_rsp;
    soc_pkg::wb_rsp_t ic_rsp;
    logic             timer_int;

    // ----------------------------------------
    // Address decoder
    // ----------------------------------------
    wb_decoder u_wb_decoder (
        .i_clk       ( i_clk     ),
        .i_rst_n     ( i_rst_n   ),
        .i_wb_req    ( i_wb_req  ),
        .o_wb_rsp    ( o_wb_rsp  ),
        .o_boot_req  ( boot_req  ),
        .o_timer_req ( timer_req ),
        .o_ic_req    ( ic_req    ),
        .i_boot_rsp  ( boot_rsp  ),
        .i_timer_rsp ( timer_rsp ),
        .i_ic_rsp    ( ic_rsp    )
    );

    // ----------------------------------------
    // Slaves
    // ----------------------------------------
    boot_mem #(
        .BOOT_MEM_WORDS ( BOOT_MEM_WORDS )
    ) u_boot_mem (
        .i_clk    ( i_clk    ),
        .i_rst_n  ( i_rst_n  ),
        .i_wb_req ( boot_req ),
        .o_wb_rsp ( boot_rsp )
    );

    timer_module u_timer_module (
        .i_clk       ( i_clk     ),
        .i_rst_n     ( i_rst_n   ),
        .i_wb_req    ( timer_req ),
        .o_wb_rsp    ( timer_rsp ),
        .o_timer_int ( timer_int )
    );

    // Timer event reaches the processor through the status register here
    interrupt_controller u_interrupt_controller (
        .i_clk       ( i_clk     ),
        .i_rst_n     ( i_rst_n   ),
        .i_wb_req    ( ic_req    ),
        .o_wb_rsp    ( ic_rsp    ),
        .i_timer_int ( timer_int ),
        .i_ext_irq   ( i_ext_irq ),
        .o_irq       ( o_irq     ),
        .o_firq      ( o_firq    )
    );

endmodule

//--- verif/soc_assertions.sv
/*
 * Bus and interrupt assertions
 * Bound into the SoC top level to watch the Wishbone port and irq lines
 */
`timescale 1ns/1ps

module soc_assertions (
    input logic                          i_clk,
    input logic                          i_rst_n,
    input soc_pkg::wb_req_t              i_wb_req,
    input soc_pkg::wb_rsp_t              i_wb_rsp,
    input logic                          i_irq,
    input logic                          i_firq,
    input logic [soc_pkg::INT_SRC_W-1:0] i_irq_en
);

    // Number of failed properties so far
    int unsigned fail_count = 0;

    // ----------------------------------------
    // Reset
    // ----------------------------------------
    reset_quiet: assert property (@(posedge i_clk)
        !i_rst_n |-> !i_wb_rsp.ack && !i_wb_rsp.err && !i_irq && !i_firq)
    else begin
        $error("Response or interrupt active during reset");
        fail_count++;
    end

    // ----------------------------------------
    // Wishbone handshake
    // ----------------------------------------
    ack_err_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_wb_rsp.ack && i_wb_rsp.err))
    else begin
        $error("ack and err high together");
        fail_count++;
    end

    ack_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wb_rsp.ack |=> !i_wb_rsp.ack)
    else begin
        $error("ack held longer than one cycle");
        fail_count++;
    end

    err_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wb_rsp.err |=> !i_wb_rsp.err)
    else begin
        $error("err held longer than one cycle");
        fail_count++;
    end

    // A response needs a strobe in the cycle before
    rsp_after_stb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_wb_rsp.ack || i_wb_rsp.err) |-> $past(i_wb_req.cyc && i_wb_req.stb))
    else begin
        $error("Response without a preceding strobe");
        fail_count++;
    end

    irq_needs_enable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_irq) |-> (i_irq_en != '0))
    else begin
        $error("irq rose with both irq enables clear");
        fail_count++;
    end

endmodule

bind soc_top soc_assertions u_soc_assertions (
    .i_clk    ( i_clk                           ),
    .i_rst_n  ( i_rst_n                         ),
    .i_wb_req ( i_wb_req                        ),
    .i_wb_rsp ( o_wb_rsp                        ),
    .i_irq    ( o_irq                           ),
    .i_firq   ( o_firq                          ),
    .i_irq_en ( u_interrupt_controller.irq_en_r )
);

//--- verif/tb_soc.sv
/*
 * SoC testbench
 * Drives the Wishbone master port through boot memory, unmapped space,
 * the timer interrupt and the interrupt masks
 */
`timescale 1ns/1ps

module tb_soc;

    localparam int CLK_PERIOD = 8;
    localparam int MEM_WORDS  = 256;
    localparam int N_WORDS    = 16;
    localparam int N_UNMAPPED = 4;
    localparam int BUS_CYCLES = 3;
    // Reset, boot memory, unmapped, timer and mask phases
    localparam int TEST_CYCLES = 10 + 3 * N_WORDS * BUS_CYCLES
                                 + N_UNMAPPED * BUS_CYCLES + 13 * BUS_CYCLES + 60;

    logic             clk;
    logic             rst_n;
    soc_pkg::wb_req_t wb_req;
    soc_pkg::wb_rsp_t wb_rsp;
    logic             ext_irq;
    logic             irq;
    logic             firq;
    int               edge_no = 0;
    int               ack_edge;
    logic [31:0]      ref_mem [MEM_WORDS];

    soc_top #(
        .BOOT_MEM_WORDS ( MEM_WORDS )
    ) dut_i (
        .i_clk     ( clk     ),
        .i_rst_n   ( rst_n   ),
        .i_wb_req  ( wb_req  ),
        .o_wb_rsp  ( wb_rsp  ),
        .i_ext_irq ( ext_irq ),
        .o_irq     ( irq     ),
        .o_firq    ( firq    )
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Edge count, read at falling edges
    always @(posedge clk) edge_no <= edge_no + 1;

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("Checks failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else report_error($sformatf("%s got 0x%08h expected 0x%08h", what, got, exp));
    endtask

    // ----------------------------------------
    // Bus master
    // ----------------------------------------
    task automatic bus_access(input logic [7:0] region, input logic [23:0] offset,
                              input logic we, input logic [3:0] sel,
                              input logic [31:0] wdat, input logic expect_err,
                              output logic [31:0] rdat);
        int waited;
        @(posedge clk);
        wb_req.adr.fields.region <= region;
        wb_req.adr.fields.offset <= offset;
        wb_req.we  <= we;
        wb_req.sel <= sel;
        wb_req.dat <= wdat;
        wb_req.cyc <= 1'b1;
        wb_req.stb <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            @(negedge clk);
        end while (!wb_rsp.ack && !wb_rsp.err);
        ack_edge = edge_no;
        rdat = wb_rsp.dat;
        check_value("response latency", waited, 1);
        check_value("err flag", wb_rsp.err, expect_err);
        check_value("ack flag", wb_rsp.ack, !expect_err);
        @(posedge clk);
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
    endtask

    task automatic bus_write(input logic [7:0] region, input logic [23:0] offset,
                             input logic [3:0] sel, input logic [31:0] wdat);
        logic [31:0] unused;
        bus_access(region, offset, 1'b1, sel, wdat, 1'b0, unused);
    endtask

    task automatic bus_read(input logic [7:0] region, input logic [23:0] offset,
                            output logic [31:0] rdat);
        bus_access(region, offset, 1'b0, 4'hF, 32'h0, 1'b0, rdat);
    endtask

    task automatic wait_irq_rise(output int rise_edge);
        @(negedge clk);
        while (!irq) begin
            @(negedge clk);
        end
        rise_edge = edge_no;
    endtask

    initial begin : watchdog
        #(20 * TEST_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("Checks failed");
        $fatal(1, "Timeout");
    end

    always @(dut_i.u_soc_assertions.fail_count) begin
        if (dut_i.u_soc_assertions.fail_count != 0) begin
            $display("A bound bus or interrupt assertion failed");
            $display("Checks failed");
            $fatal(1, "Assertion failure");
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin : stimulus
        logic [31:0] rdat;
        logic [31:0] wdat;
        logic [3:0]  sel;
        logic [7:0]  region;
        int          idx_list [N_WORDS];
        int          load;
        int          rise_first;
        int          rise_next;
        int unsigned seed_used;

        rst_n   = 1'b0;
        ext_irq = 1'b0;
        wb_req  = '0;
        seed_used = $urandom(4);
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("irq after reset", irq, 0);
        check_value("firq after reset", firq, 0);
        check_value("ack after reset", wb_rsp.ack, 0);
        check_value("err after reset", wb_rsp.err, 0);

        // Full words first, then byte merges into the same words
        for (int k = 0; k < N_WORDS; k++) begin
            idx_list[k] = $urandom_range(0, MEM_WORDS - 1);
            wdat = $urandom;
            ref_mem[idx_list[k]] = wdat;
            bus_write(soc_pkg::REGION_BOOT, 24'(idx_list[k] * 4), 4'hF, wdat);
        end
        for (int k = 0; k < N_WORDS; k++) begin
            sel  = 4'($urandom_range(1, 15));
            wdat = $urandom;
            for (int b = 0; b < 4; b++) begin
                if (sel[b]) begin
                    ref_mem[idx_list[k]][b*8 +: 8] = wdat[b*8 +: 8];
                end
            end
            bus_write(soc_pkg::REGION_BOOT, 24'(idx_list[k] * 4), sel, wdat);
        end
        for (int k = 0; k < N_WORDS; k++) begin
            bus_read(soc_pkg::REGION_BOOT, 24'(idx_list[k] * 4), rdat);
            check_value("boot memory read", rdat, ref_mem[idx_list[k]]);
        end

        for (int k = 0; k < N_UNMAPPED; k++) begin
            do begin
                region = 8'($urandom_range(0, 255));
            end while (region == soc_pkg::REGION_BOOT || region == soc_pkg::REGION_TIMER
                       || region == soc_pkg::REGION_IC);
            bus_access(region, 24'($urandom) & 24'hFFFFFC, 1'($urandom_range(0, 1)), 4'hF,
                       $urandom, 1'b1, rdat);
            check_value("unmapped read data", rdat, 0);
        end

        // Flag after load+1 cycles, irq one cycle later
        load = $urandom_range(8, 15);
        bus_write(soc_pkg::REGION_TIMER, soc_pkg::TIMER_LOAD, 4'hF, load);
        bus_read(soc_pkg::REGION_TIMER, soc_pkg::TIMER_VALUE, rdat);
        check_value("timer value after load", rdat, load);
        bus_write(soc_pkg::REGION_IC, soc_pkg::IC_IRQ_EN_SET, 4'hF, 32'h1);
        bus_write(soc_pkg::REGION_TIMER, soc_pkg::TIMER_CTRL, 4'hF, 32'h1);
        wait_irq_rise(rise_first);
        check_value("cycles from enable to irq", rise_first - ack_edge, load + 2);
        bus_write(soc_pkg::REGION_TIMER, soc_pkg::TIMER_CLEAR, 4'hF, 32'h0);
        @(negedge clk);
        check_value("irq after timer clear", irq, 0);
        wait_irq_rise(rise_next);
        check_value("timer period", rise_next - rise_first, load + 1);
        bus_write(soc_pkg::REGION_TIMER, soc_pkg::TIMER_CTRL, 4'hF, 32'h0);
        bus_write(soc_pkg::REGION_IC, soc_pkg::IC_IRQ_EN_CLR, 4'hF, 32'h1);
        bus_write(soc_pkg::REGION_TIMER, soc_pkg::TIMER_CLEAR, 4'hF, 32'h0);

        // External source routed to firq only
        bus_write(soc_pkg::REGION_IC, soc_pkg::IC_FIRQ_EN_SET, 4'hF, 32'h2);
        @(posedge clk);
        ext_irq <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_value("firq with external source", firq, 1);
        check_value("irq with external source", irq, 0);
        bus_read(soc_pkg::REGION_IC, soc_pkg::IC_FIRQ_EN_SET, rdat);
        check_value("firq enable mask", rdat, 32'h2);
        bus_read(soc_pkg::REGION_IC, soc_pkg::IC_RAW, rdat);
        check_value("raw status", rdat, 32'h2);
        bus_read(soc_pkg::REGION_IC, soc_pkg::IC_STATUS, rdat);
        check_value("masked status", rdat, 32'h0);
        bus_write(soc_pkg::REGION_IC, soc_pkg::IC_FIRQ_EN_CLR, 4'hF, 32'h2);
        @(negedge clk);
        check_value("firq after enable clear", firq, 0);
        @(posedge clk);
        ext_irq <= 1'b0;
        repeat (2) @(posedge clk);

        // Bound assertions act after the edge, so settle before the end
        @(negedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule

//--- list.f
logic/soc_pkg.sv
logic/wb_decoder.sv
logic/boot_mem.sv
logic/timer_module.sv
logic/interrupt_controller.sv
logic/soc_top.sv
verif/soc_assertions.sv
verif/tb_soc.sv
